//--- compile.f
+incdir+.
gb_pkg.sv
gb_mem_map.sv
gb_irq_ctrl.sv
gb_joypad.sv
gb_serial.sv
gb_wram.sv
gb_sys.sv
tb_gb_sys.sv

//--- tb_gb_sys.sv
// plays the cpu bus of gb_sys with boot rom and cartridge as address patterns; serial waits ~4100 cycles
`timescale 1ns/100ps
`default_nettype none

`include "gb_cfg.svh"

module tb_gb_sys;

	logic        clk_cpu, reset, fast_boot, is_gbc;
	logic [7:0]  joystick, cpu_do, cpu_di, cart_do, cart_di;
	logic [7:0]  boot_rom_data, boot_rom_addr;
	logic [15:0] cpu_addr, cart_addr;
	logic        cpu_rd_n, cpu_wr_n, cpu_iorq_n, cpu_m1_n;
	logic        irq_n, cart_rd, cart_wr;
	logic        rd_strobe, wr_strobe;     // cart strobes seen in the last access
	logic [15:0] wr_addr;                  // cart address seen in the last write
	logic [7:0]  wr_data;                  // cart write data seen in the last write
	logic [7:0]  rdata, r0, r1, r2;
	logic [7:0]  zp_data [0:5];
	int          errors, checks, test_start;

	gb_sys DUT (
		.clk_cpu(clk_cpu), .reset(reset), .fast_boot(fast_boot), .is_gbc(is_gbc),
		.joystick(joystick), .cpu_addr(cpu_addr), .cpu_do(cpu_do), .cpu_rd_n(cpu_rd_n),
		.cpu_wr_n(cpu_wr_n), .cpu_iorq_n(cpu_iorq_n), .cpu_m1_n(cpu_m1_n),
		.cart_do(cart_do), .boot_rom_data(boot_rom_data), .cpu_di(cpu_di), .irq_n(irq_n),
		.cart_addr(cart_addr), .cart_rd(cart_rd), .cart_wr(cart_wr), .cart_di(cart_di),
		.boot_rom_addr(boot_rom_addr)
	);

	// ------------------------------------------------------------------------
	// rom models, contents follow the whole address
	function automatic logic [7:0] boot_byte(input logic [7:0] addr);
		return addr ^ 8'ha5;
	endfunction

	function automatic logic [7:0] cart_byte(input logic [15:0] addr);
		return addr[15:8] ^ addr[7:0] ^ 8'h3c;
	endfunction

	assign boot_rom_data = boot_byte(boot_rom_addr);
	assign cart_do       = cart_byte(cart_addr);

	function automatic logic [7:0] rand_byte();
		logic [31:0] word;
		word = $urandom;
		return word[7:0];
	endfunction

	initial begin
		clk_cpu = 1'b0;
		forever #10 clk_cpu = ~clk_cpu;      // 50 MHz
	end

	// ------------------------------------------------------------------------
	// bus cycles, inputs change on the falling edge only
	task automatic do_write(input logic [15:0] addr, input logic [7:0] data);
		@(negedge clk_cpu);
		cpu_addr = addr;
		cpu_do   = data;
		cpu_wr_n = 1'b0;                     // one rising edge with wr low
		@(negedge clk_cpu);
		wr_strobe = cart_wr;
		wr_addr   = cart_addr;
		wr_data   = cart_di;
		cpu_wr_n  = 1'b1;
	endtask

	task automatic do_read(input logic [15:0] addr, output logic [7:0] data);
		@(negedge clk_cpu);
		cpu_addr = addr;
		cpu_rd_n = 1'b0;
		repeat (2) @(negedge clk_cpu);       // ram data is one cycle late
		data      = cpu_di;
		rd_strobe = cart_rd;
		cpu_rd_n  = 1'b1;
	endtask

	task automatic do_ack(output logic [7:0] vec);
		@(negedge clk_cpu);
		cpu_iorq_n = 1'b0;
		cpu_m1_n   = 1'b0;
		@(negedge clk_cpu);
		vec        = cpu_di;                 // vector shows during the ack
		cpu_iorq_n = 1'b1;
		cpu_m1_n   = 1'b1;
	endtask

	task automatic check_value(input string name, input logic [15:0] got,
		input logic [15:0] exp);
		checks++;
		assert (got === exp) else begin
			$display("Mismatch %s: got %h expected %h", name, got, exp);
			errors++;
		end
	endtask

	// poll IF until the bit shows up, each read costs 3 cycles
	task automatic wait_if_bit(input int bit_idx, input int max_cycles);
		logic [7:0] flags;
		int         waited;
		flags  = 8'h00;
		waited = 0;
		while (!flags[bit_idx] && waited < max_cycles) begin
			do_read(`ADDR_IF, flags);
			waited += 3;
		end
		checks++;
		assert (flags[bit_idx]) else begin
			$display("IF bit %0d was not set within %0d cycles", bit_idx, max_cycles);
			errors++;
		end
	endtask

	task automatic end_test(input string name);
		$display("test %s done, %0d errors", name, errors - test_start);
		test_start = errors;
	endtask

	// ------------------------------------------------------------------------
	initial begin
		void'($urandom(32'h6387_79af));
		errors     = 0;
		checks     = 0;
		test_start = 0;
		reset      = 1'b1;
		fast_boot  = 1'b1;
		is_gbc     = 1'b0;                   // dmg first
		joystick   = 8'h00;
		cpu_addr   = 16'h0000;
		cpu_do     = 8'h00;
		cpu_rd_n   = 1'b1;
		cpu_wr_n   = 1'b1;
		cpu_iorq_n = 1'b1;
		cpu_m1_n   = 1'b1;
		rd_strobe  = 1'b0;
		wr_strobe  = 1'b0;
		wr_addr    = 16'h0000;
		wr_data    = 8'h00;
		repeat (2) @(posedge clk_cpu);
		@(negedge clk_cpu);
		reset = 1'b0;

		// boot overlay, fast flag, then cartridge behind it
		r0 = rand_byte();
		do_read({8'h00, r0}, rdata);
		check_value("cpu_di", rdata, boot_byte(r0));
		do_read(16'h00ff, rdata);
		check_value("cpu_di", rdata, boot_byte(8'hff));
		do_read(`ADDR_BOOT, rdata);
		check_value("cpu_di", rdata, 8'h42);
		do_write(`ADDR_BOOT, 8'h01);         // dmg, odd value drops overlay
		do_read(16'h0000, rdata);
		check_value("cpu_di", rdata, cart_byte(16'h0000));
		check_value("cart_rd", rd_strobe, 1'b1);
		r1 = rand_byte();
		do_write(16'ha000, r1);
		check_value("cart_wr", wr_strobe, 1'b1);
		check_value("cart_addr", wr_addr, 16'ha000);
		check_value("cart_di", wr_data, r1);
		end_test("boot_cart");

		// banked work ram in colour mode
		is_gbc = 1'b1;
		r0 = rand_byte();
		r1 = rand_byte();
		r2 = rand_byte();
		do_write(`ADDR_SVBK, 8'h02);
		do_write(16'hd000, r0);
		do_write(`ADDR_SVBK, 8'h03);
		do_write(16'hd000, r1);
		do_write(16'hc000, r2);              // fixed bank 0
		do_write(`ADDR_SVBK, 8'h02);
		do_read(16'hd000, rdata);
		check_value("cpu_di", rdata, r0);
		do_write(`ADDR_SVBK, 8'h03);
		do_read(16'hd000, rdata);
		check_value("cpu_di", rdata, r1);
		do_read(16'hc000, rdata);
		check_value("cpu_di", rdata, r2);
		do_write(`ADDR_SVBK, 8'h00);
		do_read(`ADDR_SVBK, rdata);
		check_value("svbk", rdata, 8'hf9);   // bank 0 reads as 1
		end_test("wram");

		// zero page and IE
		for (int i = 0; i < 6; i++) begin
			zp_data[i] = rand_byte();
			do_write({8'hff, 1'b1, i[6:0]}, zp_data[i]);
		end
		for (int i = 0; i < 6; i++) begin
			do_read({8'hff, 1'b1, i[6:0]}, rdata);
			check_value("cpu_di", rdata, zp_data[i]);
		end
		r0 = rand_byte();
		do_write(`ADDR_IE, r0);
		do_read(`ADDR_IE, rdata);
		check_value("ie", rdata, {3'b000, r0[4:0]});
		end_test("zp_ie");

		// joypad matrix and falling-edge irq
		r0 = rand_byte();
		joystick = {4'h0, r0[3:0]};          // directions only
		do_write(`ADDR_P1, 8'h20);           // p14 low selects directions
		do_read(`ADDR_P1, rdata);
		check_value("p1", rdata, {4'b1110, ~r0[3:0]});
		joystick = 8'h00;
		repeat (4) @(negedge clk_cpu);       // let the synchroniser settle
		do_write(`ADDR_IF, 8'h00);
		do_read(`ADDR_IF, rdata);
		check_value("if", rdata, 8'he0);     // no flag before the press
		joystick = 8'h04;                    // press up
		wait_if_bit(4, 30);
		end_test("joypad");

		// priority, bit 0 wins
		do_write(`ADDR_IE, 8'h1f);
		do_write(`ADDR_IF, 8'h0a);           // lcdc and serial
		check_value("irq_n", irq_n, 1'b0);
		do_ack(rdata);
		check_value("vector", rdata, 8'h48);  // lcdc
		do_read(`ADDR_IF, rdata);
		check_value("if", rdata, 8'he8);
		do_ack(rdata);
		check_value("vector", rdata, 8'h58);  // serial
		do_read(`ADDR_IF, rdata);
		check_value("if", rdata, 8'he0);
		check_value("irq_n", irq_n, 1'b1);
		do_ack(rdata);
		check_value("vector", rdata, 8'h55);  // nothing pending
		end_test("irq");

		// serial transfer on the internal clock
		do_write(`ADDR_IF, 8'h00);
		do_write(`ADDR_SC, 8'h81);
		do_read(`ADDR_SC, rdata);
		check_value("sc", rdata, 8'hff);
		wait_if_bit(3, 6000);
		do_read(`ADDR_SC, rdata);
		check_value("sc", rdata, 8'h7f);     // start bit dropped
		end_test("serial");

		$display("6 tests, %0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- gb_sys.sv
// system glue around an external 8-bit cpu bus; boot rom and cartridge are outside, one clock
`timescale 1ns/100ps
`default_nettype none

`include "gb_cfg.svh"

module gb_sys import gb_pkg::*; (
	input  logic                  clk_cpu,
	input  logic                  reset,
	input  logic                  fast_boot,
	input  logic                  is_gbc,
	input  logic [7:0]            joystick,
	input  cpu_addr_u             cpu_addr,
	input  logic [`GB_DATA_W-1:0] cpu_do,
	input  logic                  cpu_rd_n,
	input  logic                  cpu_wr_n,
	input  logic                  cpu_iorq_n,
	input  logic                  cpu_m1_n,
	input  logic [7:0]            cart_do,
	input  logic [7:0]            boot_rom_data,
	output logic [`GB_DATA_W-1:0] cpu_di,
	output logic                  irq_n,
	output logic [`GB_ADDR_W-1:0] cart_addr,
	output logic                  cart_rd,
	output logic                  cart_wr,
	output logic [`GB_DATA_W-1:0] cart_di,
	output logic [7:0]            boot_rom_addr
);

	logic                 p1_wr, sc_wr, if_wr, ie_wr, svbk_wr;
	logic                 wram_sel, zp_sel;
	logic                 irq_ack, serial_irq, joy_irq;
	logic [7:0]           irq_vec, joy_do, sc_do, wram_do;
	logic [`GB_IRQ_N-1:0] if_q, ie_q;
	logic [2:0]           svbk_q;

	gb_mem_map u_mem_map (
		.clk_cpu(clk_cpu), .reset(reset), .fast_boot(fast_boot), .is_gbc(is_gbc),
		.cpu_addr(cpu_addr), .cpu_do(cpu_do), .cpu_rd_n(cpu_rd_n), .cpu_wr_n(cpu_wr_n),
		.irq_ack(irq_ack), .irq_vec(irq_vec), .if_q(if_q), .ie_q(ie_q),
		.joy_do(joy_do), .sc_do(sc_do), .wram_do(wram_do), .svbk_q(svbk_q),
		.cart_do(cart_do), .boot_rom_data(boot_rom_data),
		.p1_wr(p1_wr), .sc_wr(sc_wr), .if_wr(if_wr), .ie_wr(ie_wr),
		.wram_sel(wram_sel), .zp_sel(zp_sel), .svbk_wr(svbk_wr), .cpu_di(cpu_di),
		.cart_addr(cart_addr), .cart_rd(cart_rd), .cart_wr(cart_wr), .cart_di(cart_di),
		.boot_rom_addr(boot_rom_addr)
	);

	gb_irq_ctrl u_irq_ctrl (
		.clk_cpu(clk_cpu), .reset(reset), .cpu_do(cpu_do),
		.cpu_iorq_n(cpu_iorq_n), .cpu_m1_n(cpu_m1_n), .if_wr(if_wr), .ie_wr(ie_wr),
		.serial_irq(serial_irq), .joy_irq(joy_irq), .if_q(if_q), .ie_q(ie_q),
		.irq_ack(irq_ack), .irq_vec(irq_vec), .irq_n(irq_n)
	);

	gb_joypad u_joypad (
		.clk_cpu(clk_cpu), .reset(reset), .joystick(joystick), .cpu_do(cpu_do),
		.p1_wr(p1_wr), .joy_do(joy_do), .joy_irq(joy_irq)
	);

	gb_serial u_serial (
		.clk_cpu(clk_cpu), .reset(reset), .cpu_do(cpu_do), .sc_wr(sc_wr),
		.sc_do(sc_do), .serial_irq(serial_irq)
	);

	gb_wram u_wram (
		.clk_cpu(clk_cpu), .reset(reset), .is_gbc(is_gbc), .cpu_addr(cpu_addr),
		.cpu_do(cpu_do), .cpu_wr_n(cpu_wr_n), .wram_sel(wram_sel), .zp_sel(zp_sel),
		.svbk_wr(svbk_wr), .wram_do(wram_do), .svbk_q(svbk_q)
	);

endmodule

`default_nettype wire

//--- gb_wram.sv
// work and zero-page RAM, read data one cycle after the address; SVBK only applies in cgb mode
`timescale 1ns/100ps
`default_nettype none

`include "gb_cfg.svh"

module gb_wram import gb_pkg::*; (
	input  logic                  clk_cpu,
	input  logic                  reset,
	input  logic                  is_gbc,
	input  cpu_addr_u             cpu_addr,
	input  logic [`GB_DATA_W-1:0] cpu_do,
	input  logic                  cpu_wr_n,
	input  logic                  wram_sel,
	input  logic                  zp_sel,
	input  logic                  svbk_wr,
	output logic [7:0]            wram_do,
	output logic [2:0]            svbk_q
);

	logic [7:0]              wram_mem [0:(1<<`WRAM_ADDR_W)-1];
	logic [7:0]              zp_mem   [0:(1<<`ZP_ADDR_W)-1];   // top entry is IE, never hit
	logic [`WRAM_ADDR_W-1:0] wram_addr;
	logic [2:0]              bank;
	logic [7:0]              wram_q;
	logic [7:0]              zp_q;
	logic                    zp_sel_q;   // which ram answered last cycle

	// c000 bank 0 fixed, d000 switchable (dmg always bank 1)
	assign bank      = cpu_addr.flat[12] ? (is_gbc ? svbk_q : 3'd1) : 3'd0;
	assign wram_addr = {bank, cpu_addr.flat[11:0]};
	assign wram_do   = zp_sel_q ? zp_q : wram_q;

	always_ff @(posedge clk_cpu) begin
		if (reset) begin
			svbk_q   <= 3'd1;
			zp_sel_q <= 1'b0;
		end else begin
			zp_sel_q <= zp_sel;
			if (svbk_wr)
				svbk_q <= (cpu_do[2:0] == 3'd0) ? 3'd1 : cpu_do[2:0];   // bank 0 maps to 1
		end
	end

	// ------------------------------------------------------------------------
	// ram arrays, read during write returns old data
	always_ff @(posedge clk_cpu) begin
		if (wram_sel && !cpu_wr_n)
			wram_mem[wram_addr] <= cpu_do;
		if (zp_sel && !cpu_wr_n)
			zp_mem[cpu_addr.pg.offset[`ZP_ADDR_W-1:0]] <= cpu_do;
		wram_q <= wram_mem[wram_addr];
		zp_q   <= zp_mem[cpu_addr.pg.offset[`ZP_ADDR_W-1:0]];
	end

endmodule

`default_nettype wire

//--- gb_serial.sv
// dummy serial port with no partner; only internal clock transfers finish, after 8 x 512 cycles
`timescale 1ns/100ps
`default_nettype none

`include "gb_cfg.svh"

module gb_serial (
	input  logic       clk_cpu,
	input  logic       reset,
	input  logic [7:0] cpu_do,
	input  logic       sc_wr,
	output logic [7:0] sc_do,
	output logic       serial_irq
);

	logic                     sc_start;      // sc bit 7
	logic                     sc_clk_sel;    // sc bit 0, internal clock
	logic [`SERIAL_DIV_W-1:0] div_q;         // 8192 hz bit clock
	logic [3:0]               bit_cnt;

	assign sc_do = {sc_start, 6'h3f, sc_clk_sel};

	always_ff @(posedge clk_cpu) begin
		if (reset) begin
			sc_start   <= 1'b0;
			sc_clk_sel <= 1'b0;
			div_q      <= '1;
			bit_cnt    <= 4'd8;
			serial_irq <= 1'b0;
		end else begin
			serial_irq <= 1'b0;
			if (sc_wr) begin
				sc_start   <= cpu_do[7];
				sc_clk_sel <= cpu_do[0];
				if (cpu_do[7]) begin            // start a transfer
					div_q   <= '1;
					bit_cnt <= 4'd8;
				end
			end else if (sc_start && sc_clk_sel) begin
				div_q <= div_q - 1'b1;
				if (bit_cnt == 4'd0) begin
					serial_irq <= 1'b1;         // all bits out
					sc_start   <= 1'b0;
				end else if (div_q == '0) begin
					bit_cnt <= bit_cnt - 4'd1;  // one bit per wrap
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- gb_joypad.sv
// P1 matrix; joystick bits are active high buttons, irq pulse comes 2 cycles after a line falls
`timescale 1ns/100ps
`default_nettype none

module gb_joypad (
	input  logic       clk_cpu,
	input  logic       reset,
	input  logic [7:0] joystick,   // right left up down a b select start
	input  logic [7:0] cpu_do,
	input  logic       p1_wr,
	output logic [7:0] joy_do,
	output logic       joy_irq
);

	logic [1:0] p1_sel;              // p15 p14, 0 selects the row
	logic [3:0] dir_row, btn_row;
	logic [7:0] sync_q1, sync_q2;

	assign dir_row = ~joystick[3:0] | {4{p1_sel[0]}};
	assign btn_row = ~joystick[7:4] | {4{p1_sel[1]}};
	assign joy_do  = {2'b11, p1_sel, dir_row & btn_row};

	always_ff @(posedge clk_cpu) begin
		if (reset) begin
			p1_sel  <= 2'b00;
			sync_q1 <= 8'hff;            // lines released
			sync_q2 <= 8'hff;
			joy_irq <= 1'b0;
		end else begin
			if (p1_wr)
				p1_sel <= cpu_do[5:4];
			sync_q1 <= {btn_row, dir_row};
			sync_q2 <= sync_q1;
			joy_irq <= |(sync_q2 & ~sync_q1);   // any high to low
		end
	end

endmodule

`default_nettype wire

//--- gb_irq_ctrl.sv
// IF/IE registers and vector; the winning flag clears on the edge after the ack cycle ends
`timescale 1ns/100ps
`default_nettype none

`include "gb_cfg.svh"

module gb_irq_ctrl import gb_pkg::*; (
	input  logic                   clk_cpu,
	input  logic                   reset,
	input  logic [`GB_DATA_W-1:0]  cpu_do,
	input  logic                   cpu_iorq_n,
	input  logic                   cpu_m1_n,
	input  logic                   if_wr,
	input  logic                   ie_wr,
	input  logic                   serial_irq,
	input  logic                   joy_irq,
	output logic [`GB_IRQ_N-1:0]   if_q,
	output logic [`GB_IRQ_N-1:0]   ie_q,
	output logic                   irq_ack,
	output logic [7:0]             irq_vec,
	output logic                   irq_n
);

	logic [`GB_IRQ_N-1:0] pending;
	logic [`GB_IRQ_N-1:0] win;           // one-hot, lowest pending bit
	logic [`GB_IRQ_N-1:0] evt;           // event pulses in flag order
	logic [2:0]           win_idx;
	logic                 ack_q;

	assign irq_ack = !cpu_iorq_n && !cpu_m1_n;
	assign pending = if_q & ie_q;
	assign irq_n   = ~|pending;

	// vblank, lcdc and timer only get set by cpu writes here
	always_comb begin
		evt             = '0;
		evt[IRQ_SERIAL] = serial_irq;
		evt[IRQ_JOYPAD] = joy_irq;
	end

	// priority search, bit 0 highest
	always_comb begin
		win     = '0;
		win_idx = 3'd0;
		for (int i = `GB_IRQ_N - 1; i >= 0; i--) begin
			if (pending[i]) begin
				win     = '0;
				win[i]  = 1'b1;
				win_idx = i[2:0];
			end
		end
		irq_vec = (|pending) ? `IRQ_VEC_BASE + `IRQ_VEC_STEP * {5'd0, win_idx}
			: `IRQ_VEC_NONE;
	end

	always_ff @(posedge clk_cpu) begin
		if (reset) begin
			if_q  <= '0;
			ie_q  <= '0;
			ack_q <= 1'b0;
		end else begin
			ack_q <= irq_ack;
			if (if_wr)
				if_q <= cpu_do[`GB_IRQ_N-1:0];               // cpu write replaces all flags
			else if (ack_q && !irq_ack)
				if_q <= (if_q & ~win) | evt;                 // ack just ended
			else
				if_q <= if_q | evt;
			if (ie_wr)
				ie_q <= cpu_do[`GB_IRQ_N-1:0];
		end
	end

endmodule

`default_nettype wire

//--- gb_mem_map.sv
// cpu address decode and read mux; writes act on every clk_cpu edge with cpu_wr_n low
`timescale 1ns/100ps
`default_nettype none

`include "gb_cfg.svh"

module gb_mem_map import gb_pkg::*; (
	input  logic                   clk_cpu,
	input  logic                   reset,
	input  logic                   fast_boot,
	input  logic                   is_gbc,
	input  cpu_addr_u              cpu_addr,
	input  logic [`GB_DATA_W-1:0]  cpu_do,
	input  logic                   cpu_rd_n,
	input  logic                   cpu_wr_n,
	input  logic                   irq_ack,
	input  logic [7:0]             irq_vec,
	input  logic [`GB_IRQ_N-1:0]   if_q,
	input  logic [`GB_IRQ_N-1:0]   ie_q,
	input  logic [7:0]             joy_do,
	input  logic [7:0]             sc_do,
	input  logic [7:0]             wram_do,
	input  logic [2:0]             svbk_q,
	input  logic [7:0]             cart_do,
	input  logic [7:0]             boot_rom_data,
	output logic                   p1_wr,
	output logic                   sc_wr,
	output logic                   if_wr,
	output logic                   ie_wr,
	output logic                   wram_sel,
	output logic                   zp_sel,
	output logic                   svbk_wr,
	output logic [`GB_DATA_W-1:0]  cpu_di,
	output logic [`GB_ADDR_W-1:0]  cart_addr,
	output logic                   cart_rd,
	output logic                   cart_wr,
	output logic [`GB_DATA_W-1:0]  cart_di,
	output logic [7:0]             boot_rom_addr
);

	logic sel_rom, sel_cram, sel_reg_page;
	logic sel_p1, sel_sb, sel_sc, sel_if, sel_ie, sel_boot, sel_svbk;
	logic sel_fast, sel_boot_rom;
	logic wr;
	logic boot_en;                         // boot rom overlays 0000..00ff

	// ------------------------------------------------------------------------
	// decode
	assign wr           = !cpu_wr_n;
	assign sel_rom      = !cpu_addr.flat[15];                     // 0000..7fff
	assign sel_cram     = cpu_addr.flat[15:13] == 3'b101;         // a000..bfff
	assign sel_reg_page = cpu_addr.pg.page == `PAGE_REG;
	assign wram_sel     = (cpu_addr.flat[15:14] == 2'b11)         // c000..fdff, echo too
		&& (cpu_addr.pg.page != `PAGE_OAM) && !sel_reg_page;
	assign zp_sel       = sel_reg_page && cpu_addr.pg.offset[7]
		&& (cpu_addr.flat != `ADDR_IE);                         // ff80..fffe

	assign sel_p1   = cpu_addr.flat == `ADDR_P1;
	assign sel_sb   = cpu_addr.flat == `ADDR_SB;
	assign sel_sc   = cpu_addr.flat == `ADDR_SC;
	assign sel_if   = cpu_addr.flat == `ADDR_IF;
	assign sel_ie   = cpu_addr.flat == `ADDR_IE;
	assign sel_boot = cpu_addr.flat == `ADDR_BOOT;
	assign sel_svbk = is_gbc && (cpu_addr.flat == `ADDR_SVBK);  // cgb only

	assign sel_fast     = fast_boot && boot_en && sel_boot;
	assign sel_boot_rom = boot_en && (cpu_addr.pg.page == `PAGE_BOOT);

	// per-block write strobes
	assign p1_wr   = sel_p1 && wr;
	assign sc_wr   = sel_sc && wr;
	assign if_wr   = sel_if && wr;
	assign ie_wr   = sel_ie && wr;
	assign svbk_wr = sel_svbk && wr;

	// ------------------------------------------------------------------------
	// boot overlay disable, cgb wants 11, dmg any odd value
	always_ff @(posedge clk_cpu) begin
		if (reset) begin
			boot_en <= 1'b1;
		end else if (sel_boot && wr) begin
			if ((is_gbc && cpu_do == 8'h11) || (!is_gbc && cpu_do[0]))
				boot_en <= 1'b0;
		end
	end

	// ------------------------------------------------------------------------
	// cpu read mux, first match wins
	always_comb begin
		if (irq_ack)
			cpu_di = irq_vec;                                // vector fetch
		else if (sel_fast)
			cpu_di = `FAST_BOOT_FLAG;
		else if (sel_if)
			cpu_di = {{(`GB_DATA_W-`GB_IRQ_N){1'b1}}, if_q};
		else if (sel_svbk)
			cpu_di = {5'h1f, svbk_q};
		else if (sel_p1)
			cpu_di = joy_do;
		else if (sel_sb)
			cpu_di = 8'hff;                                  // no link partner
		else if (sel_sc)
			cpu_di = sc_do;
		else if (sel_rom && sel_boot_rom)
			cpu_di = boot_rom_data;
		else if (sel_rom || sel_cram)
			cpu_di = cart_do;
		else if (zp_sel || wram_sel)
			cpu_di = wram_do;                                // registered in gb_wram
		else if (sel_ie)
			cpu_di = {{(`GB_DATA_W-`GB_IRQ_N){1'b0}}, ie_q};
		else
			cpu_di = 8'hff;                                  // open bus
	end

	// cartridge side, plain pass-through
	assign cart_addr     = cpu_addr.flat;
	assign cart_di       = cpu_do;
	assign cart_rd       = (sel_rom || sel_cram) && !cpu_rd_n;
	assign cart_wr       = (sel_rom || sel_cram) && wr;    // mbc writes land here
	assign boot_rom_addr = cpu_addr.pg.offset;

endmodule

`default_nettype wire

//--- gb_pkg.sv
// shared types; the address union assumes the 16-bit bus of gb_cfg.svh
`default_nettype none

`include "gb_cfg.svh"

package gb_pkg;

	// one cpu address word, flat or split into page and offset
	typedef union packed {
		logic [`GB_ADDR_W-1:0] flat;
		struct packed {
			logic [7:0] page;     // high byte, ffxx io page etc
			logic [7:0] offset;   // low byte
		} pg;
	} cpu_addr_u;

	// bit positions in IF and IE
	typedef enum logic [2:0] {
		IRQ_VBLANK = 3'd0,
		IRQ_LCDC   = 3'd1,
		IRQ_TIMER  = 3'd2,
		IRQ_SERIAL = 3'd3,
		IRQ_JOYPAD = 3'd4
	} irq_bit_e;

endpackage

`default_nettype wire

//--- gb_cfg.svh
// map, register addresses and widths for a 16-bit cpu address bus, 8-bit data, one cpu clock
`ifndef GB_CFG_SVH
`define GB_CFG_SVH

// bus and memory widths
`define GB_ADDR_W      16
`define GB_DATA_W      8
`define GB_IRQ_N       5
`define WRAM_ADDR_W    15             // 32k, 8 banks of 4k
`define ZP_ADDR_W      7              // ff80..fffe

// memory map pages
`define PAGE_BOOT      8'h00          // boot overlay, 0000..00ff
`define PAGE_OAM       8'hfe
`define PAGE_REG       8'hff

// io registers
`define ADDR_P1        16'hff00
`define ADDR_SB        16'hff01
`define ADDR_SC        16'hff02
`define ADDR_IF        16'hff0f
`define ADDR_BOOT      16'hff50
`define ADDR_SVBK      16'hff70
`define ADDR_IE        16'hffff

`define FAST_BOOT_FLAG 8'h42          // seen by the boot code at ff50
`define SERIAL_DIV_W   9              // 512 cycles per shifted bit

// rst vectors, lowest pending bit wins
`define IRQ_VEC_BASE   8'h40
`define IRQ_VEC_STEP   8'd8
`define IRQ_VEC_NONE   8'h55

`endif
